// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // register index, same width in every format
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the base integer set
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // decoded instruction class
  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_op_imm,
    cls_op,
    cls_fence,
    cls_system,
    cls_illegal
  } insn_class_e;

  // register-register
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // 12-bit immediate, jalr, loads, op_imm, system
  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // stores, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // branches, offset in halfwords
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // upper immediate
  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // jal, scrambled 21-bit offset
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, every format view overlaid
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

endpackage

// ==== logic/avl_bus_pkg.sv ====
package avl_bus_pkg;

  // word address width of the memory port
  localparam int AVL_ADDR_W = 24;
  // read data width, one instruction per beat
  localparam int AVL_DATA_W = 32;

  // word address on the port
  typedef logic [AVL_ADDR_W-1:0] avl_addr_t;

  // one data word
  typedef logic [AVL_DATA_W-1:0] avl_data_t;

  // byte pc, word address shifted up by two
  typedef logic [31:0] pc_t;

endpackage

// ==== logic/insn_fetch.sv ====
module insn_fetch #(
  parameter int QUEUE_DEPTH = 4,
  parameter int CNT_W       = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  avl_bus_pkg::avl_addr_t req_addr,
  input  logic [CNT_W-1:0]       req_count,
  input  logic                   avl_ready,
  input  logic                   avl_rdata_valid,
  input  avl_bus_pkg::avl_data_t avl_rdata,
  input  logic                   pop,
  input  logic                   out_done,
  output logic                   req_ready,
  output logic                   busy,
  output logic                   avl_read_req,
  output avl_bus_pkg::avl_addr_t avl_addr,
  output logic                   push,
  output avl_bus_pkg::pc_t       push_pc,
  output avl_bus_pkg::avl_data_t push_word
);

  // enough bits to hold the full depth
  localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);

  logic [CNT_W-1:0]  reads_left;
  logic [CNT_W-1:0]  results_left;
  logic [CRED_W-1:0] credits;
  avl_bus_pkg::pc_t  ret_pc;
  logic              req_fire;
  logic              rd_fire;

  // only one request in flight
  assign req_ready = !busy;
  assign req_fire  = req_valid && req_ready;

  // read needs work left and a free slot downstream
  // both terms only grow while waiting, so req stays up until ready
  assign avl_read_req = busy && (reads_left != '0) && (credits != '0);
  assign rd_fire      = avl_read_req && avl_ready;

  // return side has no back-pressure, every beat is pushed
  assign push      = avl_rdata_valid;
  assign push_word = avl_rdata;
  assign push_pc   = ret_pc;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy         <= 1'b0;
      reads_left   <= '0;
      results_left <= '0;
      credits      <= CRED_W'(QUEUE_DEPTH);
    end
    else
    begin
      // credit leaves on issue, comes back when decode pops the queue
      credits <= credits - CRED_W'(rd_fire) + CRED_W'(pop);
      if (req_fire)
      begin
        busy         <= 1'b1;
        reads_left   <= req_count;
        results_left <= req_count;
      end
      else
      begin
        if (rd_fire)
          reads_left <= reads_left - 1'b1;
        if (out_done)
        begin
          results_left <= results_left - 1'b1;
          // last result taken at the output
          if (results_left == CNT_W'(1))
            busy <= 1'b0;
        end
      end
    end
  end

  // address and pc counters, loaded on each request
  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      avl_addr <= req_addr;
      ret_pc   <= avl_bus_pkg::pc_t'({req_addr, 2'b00});
    end
    else
    begin
      if (rd_fire)
        avl_addr <= avl_addr + 1'b1;
      // data comes back in order, so pc just walks by a word
      if (avl_rdata_valid)
        ret_pc <= ret_pc + 32'd4;
    end
  end

endmodule

// ==== logic/insn_queue.sv ====
module insn_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  avl_bus_pkg::pc_t       push_pc,
  input  avl_bus_pkg::avl_data_t push_word,
  input  logic                   q_ready,
  output logic                   q_valid,
  output avl_bus_pkg::pc_t       q_pc,
  output avl_bus_pkg::avl_data_t q_word,
  output logic                   pop
);

  // depth is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  avl_bus_pkg::pc_t       pc_mem [QUEUE_DEPTH];
  avl_bus_pkg::avl_data_t word_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W:0]         count;

  assign q_valid = (count != '0);
  // pop also goes back to the fetcher as a credit
  assign pop     = q_valid && q_ready;

  // head read straight from storage
  assign q_pc   = pc_mem[rd_ptr];
  assign q_word = word_mem[rd_ptr];

  // no full check, fetch credits keep a slot free for every push
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      pc_mem[wr_ptr]   <= push_pc;
      word_mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

endmodule

// ==== logic/insn_decode.sv ====
module insn_decode (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    q_valid,
  input  avl_bus_pkg::pc_t        q_pc,
  input  avl_bus_pkg::avl_data_t  q_word,
  input  logic                    out_ready,
  output logic                    q_ready,
  output logic                    out_done,
  output logic                    out_valid,
  output avl_bus_pkg::pc_t        out_pc,
  output avl_bus_pkg::avl_data_t  out_word,
  output rv_isa_pkg::insn_class_e out_class,
  output rv_isa_pkg::reg_idx_t    out_rd,
  output rv_isa_pkg::reg_idx_t    out_rs1,
  output rv_isa_pkg::reg_idx_t    out_rs2,
  output avl_bus_pkg::avl_data_t  out_imm,
  output logic                    out_illegal
);

  rv_isa_pkg::insn_u       insn;
  rv_isa_pkg::insn_class_e d_class;
  rv_isa_pkg::reg_idx_t    d_rd;
  rv_isa_pkg::reg_idx_t    d_rs1;
  rv_isa_pkg::reg_idx_t    d_rs2;
  avl_bus_pkg::avl_data_t  d_imm;
  logic                    load;

  assign insn = q_word;

  // class from opcode, then funct3 holes
  // low bits other than 11 never match an opcode, so they land in default
  always_comb
  begin
    case (insn.r_fmt.opcode)
      rv_isa_pkg::OPC_LUI:    d_class = rv_isa_pkg::cls_lui;
      rv_isa_pkg::OPC_AUIPC:  d_class = rv_isa_pkg::cls_auipc;
      rv_isa_pkg::OPC_JAL:    d_class = rv_isa_pkg::cls_jal;
      rv_isa_pkg::OPC_JALR:   d_class = rv_isa_pkg::cls_jalr;
      rv_isa_pkg::OPC_BRANCH:
        d_class = (insn.b_fmt.funct3 inside {3'b010, 3'b011}) ?
                  rv_isa_pkg::cls_illegal : rv_isa_pkg::cls_branch;
      rv_isa_pkg::OPC_LOAD:
        d_class = (insn.i_fmt.funct3 inside {3'b011, 3'b110, 3'b111}) ?
                  rv_isa_pkg::cls_illegal : rv_isa_pkg::cls_load;
      rv_isa_pkg::OPC_STORE:
        d_class = (insn.s_fmt.funct3 >= 3'b011) ?
                  rv_isa_pkg::cls_illegal : rv_isa_pkg::cls_store;
      rv_isa_pkg::OPC_OP_IMM: d_class = rv_isa_pkg::cls_op_imm;
      rv_isa_pkg::OPC_OP:     d_class = rv_isa_pkg::cls_op;
      rv_isa_pkg::OPC_FENCE:  d_class = rv_isa_pkg::cls_fence;
      rv_isa_pkg::OPC_SYSTEM: d_class = rv_isa_pkg::cls_system;
      default:                d_class = rv_isa_pkg::cls_illegal;
    endcase
  end

  // sign-extended immediate per format
  always_comb
  begin
    case (d_class)
      rv_isa_pkg::cls_jalr, rv_isa_pkg::cls_load,
      rv_isa_pkg::cls_op_imm, rv_isa_pkg::cls_system:
        d_imm = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
      rv_isa_pkg::cls_store:
        d_imm = {{20{insn.s_fmt.imm_11_5[6]}}, insn.s_fmt.imm_11_5, insn.s_fmt.imm_4_0};
      rv_isa_pkg::cls_branch:
        d_imm = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                 insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
      rv_isa_pkg::cls_lui, rv_isa_pkg::cls_auipc:
        d_imm = {insn.u_fmt.imm_31_12, 12'h000};
      rv_isa_pkg::cls_jal:
        d_imm = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                 insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};
      // op, fence and illegal carry no immediate
      default:
        d_imm = '0;
    endcase
  end

  // register fields sit at the same bits in all formats
  // unused ones read as zero
  assign d_rd  = (d_class inside {rv_isa_pkg::cls_branch, rv_isa_pkg::cls_store,
                                  rv_isa_pkg::cls_illegal}) ? '0 : insn.r_fmt.rd;
  assign d_rs1 = (d_class inside {rv_isa_pkg::cls_lui, rv_isa_pkg::cls_auipc,
                                  rv_isa_pkg::cls_jal, rv_isa_pkg::cls_illegal}) ?
                 '0 : insn.r_fmt.rs1;
  assign d_rs2 = (d_class inside {rv_isa_pkg::cls_branch, rv_isa_pkg::cls_store,
                                  rv_isa_pkg::cls_op}) ? insn.r_fmt.rs2 : '0;

  // take a word when empty or when the held one leaves this cycle
  assign q_ready  = !out_valid || out_ready;
  assign load     = q_valid && q_ready;
  // one pulse per result handed off
  assign out_done = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else if (load)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  // payload only moves on load, so it holds through a stall
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      out_pc      <= q_pc;
      out_word    <= q_word;
      out_class   <= d_class;
      out_rd      <= d_rd;
      out_rs1     <= d_rs1;
      out_rs2     <= d_rs2;
      out_imm     <= d_imm;
      out_illegal <= (d_class == rv_isa_pkg::cls_illegal);
    end
  end

endmodule

// ==== logic/fetch_decode_top.sv ====
module fetch_decode_top #(
  parameter int QUEUE_DEPTH = 4,
  parameter int CNT_W       = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  avl_bus_pkg::avl_addr_t  req_addr,
  input  logic [CNT_W-1:0]        req_count,
  output logic                    busy,
  output logic                    avl_read_req,
  output avl_bus_pkg::avl_addr_t  avl_addr,
  input  logic                    avl_ready,
  input  logic                    avl_rdata_valid,
  input  avl_bus_pkg::avl_data_t  avl_rdata,
  output logic                    out_valid,
  input  logic                    out_ready,
  output avl_bus_pkg::pc_t        out_pc,
  output avl_bus_pkg::avl_data_t  out_word,
  output rv_isa_pkg::insn_class_e out_class,
  output rv_isa_pkg::reg_idx_t    out_rd,
  output rv_isa_pkg::reg_idx_t    out_rs1,
  output rv_isa_pkg::reg_idx_t    out_rs2,
  output avl_bus_pkg::avl_data_t  out_imm,
  output logic                    out_illegal
);

  // fetch to queue
  logic                   push;
  avl_bus_pkg::pc_t       push_pc;
  avl_bus_pkg::avl_data_t push_word;
  // queue to decode
  logic                   q_valid;
  logic                   q_ready;
  avl_bus_pkg::pc_t       q_pc;
  avl_bus_pkg::avl_data_t q_word;
  // credit return and completion back to fetch
  logic                   pop;
  logic                   out_done;

  insn_fetch #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .CNT_W       (CNT_W)
  ) u_fetch (
    .clk, .rst_n, .req_valid, .req_addr, .req_count, .avl_ready, .avl_rdata_valid,
    .avl_rdata, .pop, .out_done, .req_ready, .busy, .avl_read_req, .avl_addr,
    .push, .push_pc, .push_word
  );

  insn_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk, .rst_n, .push, .push_pc, .push_word, .q_ready, .q_valid, .q_pc, .q_word, .pop
  );

  insn_decode u_decode (
    .clk, .rst_n, .q_valid, .q_pc, .q_word, .out_ready, .q_ready, .out_done,
    .out_valid, .out_pc, .out_word, .out_class, .out_rd, .out_rs1, .out_rs2,
    .out_imm, .out_illegal
  );

endmodule

// ==== dv/avl_mem_model.sv ====
module avl_mem_model #(
  parameter int SEED = 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   jitter,
  input  logic                   read_req,
  input  avl_bus_pkg::avl_addr_t addr,
  output logic                   ready,
  output logic                   rdata_valid,
  output avl_bus_pkg::avl_data_t rdata
);

  // program storage, indexed by the low address bits
  avl_bus_pkg::avl_data_t words [256];

  // reads in flight, oldest first
  avl_bus_pkg::avl_data_t ret_data [$];
  int                     ret_due [$];
  integer                 seed = SEED;
  int                     cycle;
  int                     last_due;
  int                     lat;

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      ret_data.delete();
      ret_due.delete();
      cycle       = 0;
      last_due    = 0;
      ready       <= 1'b1;
      rdata_valid <= 1'b0;
      rdata       <= '0;
    end
    else
    begin
      cycle = cycle + 1;
      // oldest read goes back once its latency has run out
      if (ret_due.size() > 0 && ret_due[0] <= cycle)
      begin
        rdata_valid <= 1'b1;
        rdata       <= ret_data.pop_front();
        void'(ret_due.pop_front());
      end
      else
        rdata_valid <= 1'b0;
      // accepted read, 1 to 4 cycles when jittering
      // due slot never earlier than the previous one, keeps order
      if (read_req && ready)
      begin
        lat = jitter ? 1 + ($random(seed) & 3) : 1;
        last_due = (cycle + lat > last_due) ? cycle + lat : last_due + 1;
        ret_data.push_back(words[addr[7:0]]);
        ret_due.push_back(last_due);
      end
      // wait states, ready low about one cycle in four
      ready <= jitter ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

endmodule

// ==== dv/fetch_decode_asserts.sv ====
module fetch_decode_asserts (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    out_valid,
  input logic                    out_ready,
  input avl_bus_pkg::pc_t        out_pc,
  input avl_bus_pkg::avl_data_t  out_word,
  input rv_isa_pkg::insn_class_e out_class,
  input rv_isa_pkg::reg_idx_t    out_rd,
  input rv_isa_pkg::reg_idx_t    out_rs1,
  input rv_isa_pkg::reg_idx_t    out_rs2,
  input avl_bus_pkg::avl_data_t  out_imm,
  input logic                    out_illegal,
  input logic                    avl_read_req,
  input avl_bus_pkg::avl_addr_t  avl_addr,
  input logic                    avl_ready
);

  // whole result word, 32+32+4+15+32+1 bits
  logic [115:0] payload;
  // failed assertions so far
  int           fail_count = 0;

  assign payload = {out_pc, out_word, out_class, out_rd, out_rs1, out_rs2, out_imm,
                    out_illegal};

  // held result frozen while the consumer stalls
  stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(payload))
  else
  begin
    $error("result payload changed or dropped during a stall");
    fail_count++;
  end

  // read command held until the memory takes it
  read_hold: assert property (@(posedge clk) disable iff (!rst_n)
    avl_read_req && !avl_ready |=> avl_read_req && $stable(avl_addr))
  else
  begin
    $error("read request dropped or address moved before ready");
    fail_count++;
  end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !out_valid && !avl_read_req)
  else
  begin
    $error("out_valid or read request high during reset");
    fail_count++;
  end

endmodule

bind fetch_decode_top fetch_decode_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_pc       (out_pc),
  .out_word     (out_word),
  .out_class    (out_class),
  .out_rd       (out_rd),
  .out_rs1      (out_rs1),
  .out_rs2      (out_rs2),
  .out_imm      (out_imm),
  .out_illegal  (out_illegal),
  .avl_read_req (avl_read_req),
  .avl_addr     (avl_addr),
  .avl_ready    (avl_ready)
);

// ==== dv/tb.sv ====
module tb;

  localparam int     QUEUE_DEPTH = 4;
  localparam int     CNT_W       = 8;
  localparam int     TIMEOUT     = 200;
  localparam integer SEED        = 32'hbbc1;

  logic                    clk;
  logic                    rst_n;
  logic                    req_valid;
  logic                    req_ready;
  avl_bus_pkg::avl_addr_t  req_addr;
  logic [CNT_W-1:0]        req_count;
  logic                    busy;
  logic                    avl_read_req;
  avl_bus_pkg::avl_addr_t  avl_addr;
  logic                    avl_ready;
  logic                    avl_rdata_valid;
  avl_bus_pkg::avl_data_t  avl_rdata;
  logic                    out_valid;
  logic                    out_ready;
  avl_bus_pkg::pc_t        out_pc;
  avl_bus_pkg::avl_data_t  out_word;
  rv_isa_pkg::insn_class_e out_class;
  rv_isa_pkg::reg_idx_t    out_rd;
  rv_isa_pkg::reg_idx_t    out_rs1;
  rv_isa_pkg::reg_idx_t    out_rs2;
  avl_bus_pkg::avl_data_t  out_imm;
  logic                    out_illegal;
  logic                    jitter;

  // words of the program under test
  avl_bus_pkg::avl_data_t prog [64];
  int                     prog_len;
  integer                 seed;
  string                  test_name;
  int                     checks;
  int                     errors;
  int                     errors_at_start;
  bit                     aborted;

  fetch_decode_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .CNT_W       (CNT_W)
  ) uut (
    .clk, .rst_n, .req_valid, .req_ready, .req_addr, .req_count, .busy,
    .avl_read_req, .avl_addr, .avl_ready, .avl_rdata_valid, .avl_rdata,
    .out_valid, .out_ready, .out_pc, .out_word, .out_class, .out_rd, .out_rs1,
    .out_rs2, .out_imm, .out_illegal
  );

  avl_mem_model #(
    .SEED (SEED)
  ) mem (
    .clk, .rst_n, .jitter, .read_req (avl_read_req), .addr (avl_addr),
    .ready (avl_ready), .rdata_valid (avl_rdata_valid), .rdata (avl_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  task automatic compare_data(input string what, input avl_bus_pkg::avl_data_t exp,
                              input avl_bus_pkg::avl_data_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic compare_class(input string what, input rv_isa_pkg::insn_class_e exp,
                               input rv_isa_pkg::insn_class_e act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %s, actual %s (%0d)", test_name, what,
               exp.name(), act.name(), act);
    end
  endtask

  task automatic compare_reg(input string what, input rv_isa_pkg::reg_idx_t exp,
                             input rv_isa_pkg::reg_idx_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected x%0d, actual x%0d", test_name, what, exp, act);
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s: timeout, %s did not come within %0d cycles", test_name, what, TIMEOUT);
    aborted = 1'b1;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    $display("%s: finished, %0d errors", test_name, errors - errors_at_start);
  endtask

  // expected decode straight from the raw bit positions
  task automatic ref_decode(input avl_bus_pkg::avl_data_t w,
                            output rv_isa_pkg::insn_class_e cls,
                            output rv_isa_pkg::reg_idx_t rd,
                            output rv_isa_pkg::reg_idx_t rs1,
                            output rv_isa_pkg::reg_idx_t rs2,
                            output avl_bus_pkg::avl_data_t imm,
                            output logic ill);
    logic [2:0] f3;
    f3 = w[14:12];
    case (w[6:0])
      rv_isa_pkg::OPC_LUI:    cls = rv_isa_pkg::cls_lui;
      rv_isa_pkg::OPC_AUIPC:  cls = rv_isa_pkg::cls_auipc;
      rv_isa_pkg::OPC_JAL:    cls = rv_isa_pkg::cls_jal;
      rv_isa_pkg::OPC_JALR:   cls = rv_isa_pkg::cls_jalr;
      rv_isa_pkg::OPC_BRANCH:
        cls = (f3 == 3'b010 || f3 == 3'b011) ? rv_isa_pkg::cls_illegal
                                             : rv_isa_pkg::cls_branch;
      rv_isa_pkg::OPC_LOAD:
        cls = (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) ? rv_isa_pkg::cls_illegal
                                                             : rv_isa_pkg::cls_load;
      rv_isa_pkg::OPC_STORE:
        cls = (f3 > 3'b010) ? rv_isa_pkg::cls_illegal : rv_isa_pkg::cls_store;
      rv_isa_pkg::OPC_OP_IMM: cls = rv_isa_pkg::cls_op_imm;
      rv_isa_pkg::OPC_OP:     cls = rv_isa_pkg::cls_op;
      rv_isa_pkg::OPC_FENCE:  cls = rv_isa_pkg::cls_fence;
      rv_isa_pkg::OPC_SYSTEM: cls = rv_isa_pkg::cls_system;
      default:                cls = rv_isa_pkg::cls_illegal;
    endcase
    // 16-bit parcels are out of scope
    if (w[1:0] != 2'b11)
      cls = rv_isa_pkg::cls_illegal;
    ill = (cls == rv_isa_pkg::cls_illegal);
    case (cls)
      rv_isa_pkg::cls_jalr, rv_isa_pkg::cls_load, rv_isa_pkg::cls_op_imm,
      rv_isa_pkg::cls_system:
        imm = {{20{w[31]}}, w[31:20]};
      rv_isa_pkg::cls_store:
        imm = {{20{w[31]}}, w[31:25], w[11:7]};
      rv_isa_pkg::cls_branch:
        imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      rv_isa_pkg::cls_lui, rv_isa_pkg::cls_auipc:
        imm = {w[31:12], 12'h000};
      rv_isa_pkg::cls_jal:
        imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:
        imm = 32'h0;
    endcase
    rd  = (ill || cls == rv_isa_pkg::cls_branch || cls == rv_isa_pkg::cls_store) ?
          5'd0 : w[11:7];
    rs1 = (ill || cls == rv_isa_pkg::cls_lui || cls == rv_isa_pkg::cls_auipc ||
           cls == rv_isa_pkg::cls_jal) ? 5'd0 : w[19:15];
    rs2 = (cls == rv_isa_pkg::cls_branch || cls == rv_isa_pkg::cls_store ||
           cls == rv_isa_pkg::cls_op) ? w[24:20] : 5'd0;
  endtask

  function automatic logic [6:0] pick_opcode(input int k);
    case (k)
      0:       return rv_isa_pkg::OPC_LUI;
      1:       return rv_isa_pkg::OPC_AUIPC;
      2:       return rv_isa_pkg::OPC_JAL;
      3:       return rv_isa_pkg::OPC_JALR;
      4:       return rv_isa_pkg::OPC_BRANCH;
      5:       return rv_isa_pkg::OPC_LOAD;
      6:       return rv_isa_pkg::OPC_STORE;
      7:       return rv_isa_pkg::OPC_OP_IMM;
      8:       return rv_isa_pkg::OPC_OP;
      9:       return rv_isa_pkg::OPC_FENCE;
      default: return rv_isa_pkg::OPC_SYSTEM;
    endcase
  endfunction

  // loads prog into memory, requests it and checks every result in order
  task automatic run_program(input avl_bus_pkg::avl_addr_t start, input bit stall);
    int                      got;
    int                      idle;
    avl_bus_pkg::avl_data_t  e_pc;
    rv_isa_pkg::insn_class_e e_cls;
    rv_isa_pkg::reg_idx_t    e_rd;
    rv_isa_pkg::reg_idx_t    e_rs1;
    rv_isa_pkg::reg_idx_t    e_rs2;
    avl_bus_pkg::avl_data_t  e_imm;
    logic                    e_ill;
    if (aborted)
      return;
    for (int i = 0; i < prog_len; i++)
      mem.words[8'(int'(start) + i)] = prog[i];
    idle = 0;
    while (!req_ready)
    begin
      @(posedge clk);
      #10;
      idle++;
      if (idle > TIMEOUT)
      begin
        report_timeout("req_ready");
        return;
      end
    end
    req_valid = 1'b1;
    req_addr  = start;
    req_count = CNT_W'(prog_len);
    @(posedge clk);
    #10;
    req_valid = 1'b0;
    got       = 0;
    idle      = 0;
    out_ready = stall ? (($random(seed) & 1) == 1) : 1'b1;
    while (got < prog_len)
    begin
      compare_flag("busy while results pending", 1'b1, busy);
      // a second request must wait until this one is done
      compare_flag("req_ready while busy", 1'b0, req_ready);
      // valid and ready both up, the transfer lands on the next edge
      if (out_valid && out_ready)
      begin
        e_pc = {6'b0, start, 2'b00} + 32'(4 * got);
        ref_decode(prog[got], e_cls, e_rd, e_rs1, e_rs2, e_imm, e_ill);
        compare_data("pc", e_pc, out_pc);
        compare_data("word", prog[got], out_word);
        compare_class("class", e_cls, out_class);
        compare_reg("rd", e_rd, out_rd);
        compare_reg("rs1", e_rs1, out_rs1);
        compare_reg("rs2", e_rs2, out_rs2);
        compare_data("imm", e_imm, out_imm);
        compare_flag("illegal", e_ill, out_illegal);
        got++;
        idle = 0;
      end
      @(posedge clk);
      #10;
      idle++;
      if (idle > TIMEOUT)
      begin
        report_timeout("out_valid");
        return;
      end
      out_ready = stall ? (($random(seed) & 1) == 1) : 1'b1;
    end
    // nothing extra behind the last result
    compare_flag("busy after last result", 1'b0, busy);
    compare_flag("out_valid after last result", 1'b0, out_valid);
    out_ready = 1'b0;
  endtask

  task automatic load_class_prog();
    // lui, auipc, jal, jalr, beq, lw, sw, addi, add, fence, csrrw
    prog[0]  = 32'h123452b7;
    prog[1]  = 32'hfffff317;
    prog[2]  = 32'hfe9ff0ef;
    prog[3]  = 32'h00808067;
    prog[4]  = 32'hfe208ee3;
    prog[5]  = 32'hff412383;
    prog[6]  = 32'h00322a23;
    prog[7]  = 32'hfff50513;
    prog[8]  = 32'h002081b3;
    prog[9]  = 32'h0ff0000f;
    prog[10] = 32'h34011073;
    prog_len = 11;
  endtask

  task automatic load_illegal_prog();
    // low bits 10, two unknown opcodes
    prog[0]  = 32'hfff50512;
    prog[1]  = 32'h0000007f;
    prog[2]  = 32'h1234502b;
    // branch funct3 010, 011
    prog[3]  = 32'h00112063;
    prog[4]  = 32'h00113063;
    // load funct3 011, 110, 111
    prog[5]  = 32'h00013083;
    prog[6]  = 32'h00016083;
    prog[7]  = 32'h00017083;
    // store funct3 011, 111
    prog[8]  = 32'h00113023;
    prog[9]  = 32'h00117023;
    prog_len = 10;
  endtask

  task automatic load_random_prog(input int n);
    for (int i = 0; i < n; i++)
    begin
      prog[i] = $random(seed);
      // every fourth word stays raw, mostly illegal
      if ((i % 4) != 3)
        prog[i][6:0] = pick_opcode(($random(seed) & 15) % 11);
    end
    prog_len = n;
  endtask

  task automatic test_reset();
    start_test("reset_state");
    compare_flag("req_ready", 1'b1, req_ready);
    compare_flag("busy", 1'b0, busy);
    compare_flag("out_valid", 1'b0, out_valid);
    compare_flag("avl_read_req", 1'b0, avl_read_req);
    finish_test();
  endtask

  task automatic test_classes();
    start_test("each_class");
    load_class_prog();
    run_program(24'h000010, 1'b0);
    finish_test();
  endtask

  task automatic test_illegal();
    start_test("illegal_words");
    load_illegal_prog();
    run_program(24'h000040, 1'b0);
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test("random_backpressure");
    load_random_prog(32);
    run_program(24'h000080, 1'b1);
    finish_test();
  endtask

  // same random words as before, now behind a slow memory
  task automatic test_slow_memory();
    start_test("slow_memory");
    jitter = 1'b1;
    run_program(24'h0000c0, 1'b1);
    jitter = 1'b0;
    finish_test();
  endtask

  task automatic test_back_to_back();
    start_test("back_to_back");
    load_class_prog();
    run_program(24'h000030, 1'b0);
    load_illegal_prog();
    run_program(24'h000048, 1'b0);
    finish_test();
  endtask

  initial
  begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_count = '0;
    out_ready = 1'b0;
    jitter    = 1'b0;
    seed      = SEED;
    checks    = 0;
    errors    = 0;
    aborted   = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_reset();
    test_classes();
    test_illegal();
    test_backpressure();
    test_slow_memory();
    test_back_to_back();
    $display("summary: %0d checks, %0d errors, %0d assertion failures, timeout %0d",
             checks, errors, uut.u_asserts.fail_count, aborted);
    if (errors == 0 && !aborted && uut.u_asserts.fail_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
logic/rv_isa_pkg.sv
logic/avl_bus_pkg.sv
logic/insn_fetch.sv
logic/insn_queue.sv
logic/insn_decode.sv
logic/fetch_decode_top.sv
dv/avl_mem_model.sv
dv/fetch_decode_asserts.sv
dv/tb.sv

// ==== run.sh ====
#!/bin/sh
# build the fetch/decode testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb \
    -Mdir obj_dir -f files.f; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi

exit 0
